// File: hdl/exu_pkg.sv
`default_nettype none

package exu_pkg;

    // datapath widths
    localparam int unsigned XLEN       = 64;
    localparam int unsigned ILEN       = 32;
    // sequential pc step
    localparam int unsigned INST_BYTES = 4;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ILEN-1:0] inst_t;

    // execute operations as handed over by decode
    // zero encoding is nop so a cleared stage register holds no work
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
        OP_LUI, OP_AUIPC,
        OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LOAD, OP_STORE,
        OP_CSRRW, OP_CSRRS, OP_ECALL, OP_MRET
    } exu_op_t;

    // machine csr addresses handled here
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;
    localparam logic [11:0] CSR_MSTATUS = 12'h300;

    localparam int unsigned CSR_NUM = 4;

    // bit positions inside csr_wen_t
    localparam int unsigned CSR_BIT_MTVEC   = 0;
    localparam int unsigned CSR_BIT_MEPC    = 1;
    localparam int unsigned CSR_BIT_MCAUSE  = 2;
    localparam int unsigned CSR_BIT_MSTATUS = 3;

    typedef logic [CSR_NUM-1:0] csr_wen_t;

    // held by the input register
    typedef struct packed {
        xlen_t   pc;
        inst_t   inst;
        exu_op_t op;
        logic    use_imm;
        xlen_t   src_a;
        xlen_t   src_b;
        xlen_t   imm;
    } issue_t;

    // held by the result register, toward memory stage
    typedef struct packed {
        xlen_t    pc;
        inst_t    inst;
        exu_op_t  op;
        xlen_t    alu_out;
        xlen_t    store_data;
        logic     redirect;
        xlen_t    dnpc;
        csr_wen_t csr_wen;
        xlen_t    csr_wdata;
    } result_t;

endpackage

`default_nettype wire

// File: hdl/exu_pipe_reg.sv
`timescale 1ns/10ps
`default_nettype none

module exu_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     up_valid,
    output logic     up_ready,
    input  payload_t up_data,
    output logic     dn_valid,
    input  logic     dn_ready,
    output payload_t dn_data
);

    logic     valid_q;
    payload_t data_q;

    // free slot, or current item leaves this cycle
    assign up_ready = !valid_q || dn_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            data_q  <= '0;
        end else if (up_ready) begin
            valid_q <= up_valid;
            // an empty slot holds a zero payload
            data_q  <= up_valid ? up_data : '0;
        end
    end

    assign dn_valid = valid_q;
    assign dn_data  = data_q;

endmodule

`default_nettype wire

// File: hdl/exu_alu.sv
`timescale 1ns/10ps
`default_nettype none

module exu_alu (
    input  exu_pkg::exu_op_t op,
    input  logic             use_imm,
    input  exu_pkg::xlen_t   pc,
    input  exu_pkg::xlen_t   src_a,
    input  exu_pkg::xlen_t   src_b,
    input  exu_pkg::xlen_t   imm,
    output exu_pkg::xlen_t   alu_out
);

    import exu_pkg::*;

    xlen_t       op_a;
    xlen_t       op_b;
    logic [5:0]  shamt;
    logic [4:0]  shamt_w;
    logic [31:0] a_lo;
    logic [31:0] b_lo;
    logic [31:0] res_w;

    // operand a
    // pc for auipc and the jump link, zero for lui
    always_comb begin
        case (op)
            OP_AUIPC, OP_JAL, OP_JALR: op_a = pc;
            OP_LUI:                    op_a = '0;
            default:                   op_a = src_a;
        endcase
    end

    // operand b
    // jumps add the pc step to form the link value
    always_comb begin
        if (op == OP_JAL || op == OP_JALR) begin
            op_b = xlen_t'(INST_BYTES);
        end else if (use_imm || op inside {OP_LUI, OP_AUIPC, OP_LOAD, OP_STORE}) begin
            op_b = imm;
        end else begin
            op_b = src_b;
        end
    end

    // 6-bit shift amount, 5-bit for word ops
    assign shamt   = op_b[5:0];
    assign shamt_w = op_b[4:0];

    assign a_lo = op_a[31:0];
    assign b_lo = op_b[31:0];

    // 32-bit word results before sign extension
    always_comb begin
        case (op)
            OP_ADDW: res_w = a_lo + b_lo;
            OP_SUBW: res_w = a_lo - b_lo;
            OP_SLLW: res_w = a_lo << shamt_w;
            OP_SRLW: res_w = a_lo >> shamt_w;
            OP_SRAW: res_w = $signed(a_lo) >>> shamt_w;
            default: res_w = '0;
        endcase
    end

    always_comb begin
        case (op)
            // adder path also gives link, load and store address
            OP_ADD, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_STORE:
                alu_out = op_a + op_b;
            OP_SUB:  alu_out = op_a - op_b;
            OP_SLL:  alu_out = op_a << shamt;
            OP_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            OP_SLTU: alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
            OP_XOR:  alu_out = op_a ^ op_b;
            OP_SRL:  alu_out = op_a >> shamt;
            OP_SRA:  alu_out = $signed(op_a) >>> shamt;
            OP_OR:   alu_out = op_a | op_b;
            OP_AND:  alu_out = op_a & op_b;
            // word results, bit 31 sign extended
            OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW:
                alu_out = {{32{res_w[31]}}, res_w};
            // old csr value goes back to rd
            OP_CSRRW, OP_CSRRS:
                alu_out = src_b;
            default: alu_out = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/exu_branch.sv
`timescale 1ns/10ps
`default_nettype none

module exu_branch (
    input  exu_pkg::exu_op_t op,
    input  exu_pkg::xlen_t   pc,
    input  exu_pkg::xlen_t   src_a,
    input  exu_pkg::xlen_t   src_b,
    input  exu_pkg::xlen_t   imm,
    output logic             redirect,
    output exu_pkg::xlen_t   dnpc
);

    import exu_pkg::*;

    xlen_t snpc;
    xlen_t rel_target;
    xlen_t jalr_sum;
    logic  take;

    assign snpc       = pc + xlen_t'(INST_BYTES);
    // shared by jal and branches
    assign rel_target = pc + imm;
    assign jalr_sum   = src_a + imm;

    // branch condition
    always_comb begin
        case (op)
            OP_BEQ:  take = src_a == src_b;
            OP_BNE:  take = src_a != src_b;
            OP_BLT:  take = $signed(src_a) < $signed(src_b);
            OP_BGE:  take = $signed(src_a) >= $signed(src_b);
            OP_BLTU: take = src_a < src_b;
            OP_BGEU: take = src_a >= src_b;
            default: take = 1'b0;
        endcase
    end

    always_comb begin
        redirect = 1'b0;
        dnpc     = snpc;
        case (op)
            OP_JAL: begin
                redirect = 1'b1;
                dnpc     = rel_target;
            end
            OP_JALR: begin
                redirect = 1'b1;
                // target lsb forced low
                dnpc     = {jalr_sum[XLEN-1:1], 1'b0};
            end
            // src_b carries mtvec or mepc from decode
            OP_ECALL, OP_MRET: begin
                redirect = 1'b1;
                dnpc     = src_b;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                if (take) begin
                    redirect = 1'b1;
                    dnpc     = rel_target;
                end
            end
            default: begin
                redirect = 1'b0;
                dnpc     = snpc;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/exu_csr_wr.sv
`timescale 1ns/10ps
`default_nettype none

module exu_csr_wr (
    input  exu_pkg::exu_op_t op,
    input  exu_pkg::inst_t   inst,
    input  exu_pkg::xlen_t   src_a,
    input  exu_pkg::xlen_t   src_b,
    output exu_pkg::csr_wen_t csr_wen,
    output exu_pkg::xlen_t   csr_wdata
);

    import exu_pkg::*;

    logic [11:0] csr_addr;
    logic        is_csr;

    // csr number sits in the i-type immediate field
    assign csr_addr = inst[31:20];
    assign is_csr   = (op == OP_CSRRW) || (op == OP_CSRRS);

    // one-hot enable, none for an unknown address
    always_comb begin
        csr_wen = '0;
        if (is_csr) begin
            case (csr_addr)
                CSR_MTVEC:   csr_wen[CSR_BIT_MTVEC]   = 1'b1;
                CSR_MEPC:    csr_wen[CSR_BIT_MEPC]    = 1'b1;
                CSR_MCAUSE:  csr_wen[CSR_BIT_MCAUSE]  = 1'b1;
                CSR_MSTATUS: csr_wen[CSR_BIT_MSTATUS] = 1'b1;
                default:     csr_wen = '0;
            endcase
        end
    end

    // src_b is the current csr value
    always_comb begin
        case (op)
            OP_CSRRW: csr_wdata = src_a;
            OP_CSRRS: csr_wdata = src_a | src_b;
            default:  csr_wdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/exu_top.sv
`timescale 1ns/10ps
`default_nettype none

module exu_top (
    input  logic              clk,
    input  logic              rst,
    // from decode
    input  logic              in_valid,
    output logic              in_ready,
    input  exu_pkg::xlen_t    in_pc,
    input  exu_pkg::inst_t    in_inst,
    input  exu_pkg::exu_op_t  in_op,
    input  logic              in_use_imm,
    input  exu_pkg::xlen_t    in_src_a,
    input  exu_pkg::xlen_t    in_src_b,
    input  exu_pkg::xlen_t    in_imm,
    // toward memory stage
    output logic              out_valid,
    input  logic              out_ready,
    output exu_pkg::xlen_t    out_pc,
    output exu_pkg::inst_t    out_inst,
    output exu_pkg::exu_op_t  out_op,
    output exu_pkg::xlen_t    out_alu,
    output exu_pkg::xlen_t    out_store_data,
    output logic              out_redirect,
    output exu_pkg::xlen_t    out_dnpc,
    output exu_pkg::csr_wen_t out_csr_wen,
    output exu_pkg::xlen_t    out_csr_wdata
);

    import exu_pkg::*;

    issue_t   issue_d;
    issue_t   issue_q;
    logic     issue_valid;
    logic     issue_ready;
    result_t  res_d;
    result_t  res_q;
    xlen_t    alu_out;
    logic     br_redirect;
    xlen_t    br_dnpc;
    csr_wen_t csr_wen;
    xlen_t    csr_wdata;

    always_comb begin
        issue_d.pc      = in_pc;
        issue_d.inst    = in_inst;
        issue_d.op      = in_op;
        issue_d.use_imm = in_use_imm;
        issue_d.src_a   = in_src_a;
        issue_d.src_b   = in_src_b;
        issue_d.imm     = in_imm;
    end

    // input register
    exu_pipe_reg #(
        .payload_t(issue_t)
    ) u_issue (
        .clk     (clk),
        .rst     (rst),
        .up_valid(in_valid),
        .up_ready(in_ready),
        .up_data (issue_d),
        .dn_valid(issue_valid),
        .dn_ready(issue_ready),
        .dn_data (issue_q)
    );

    // compute units, all combinational off the input register
    exu_alu u_alu (
        .op     (issue_q.op),
        .use_imm(issue_q.use_imm),
        .pc     (issue_q.pc),
        .src_a  (issue_q.src_a),
        .src_b  (issue_q.src_b),
        .imm    (issue_q.imm),
        .alu_out(alu_out)
    );

    exu_branch u_branch (
        .op      (issue_q.op),
        .pc      (issue_q.pc),
        .src_a   (issue_q.src_a),
        .src_b   (issue_q.src_b),
        .imm     (issue_q.imm),
        .redirect(br_redirect),
        .dnpc    (br_dnpc)
    );

    exu_csr_wr u_csr (
        .op       (issue_q.op),
        .inst     (issue_q.inst),
        .src_a    (issue_q.src_a),
        .src_b    (issue_q.src_b),
        .csr_wen  (csr_wen),
        .csr_wdata(csr_wdata)
    );

    always_comb begin
        res_d.pc         = issue_q.pc;
        res_d.inst       = issue_q.inst;
        res_d.op         = issue_q.op;
        res_d.alu_out    = alu_out;
        // store data is rs2 unchanged
        res_d.store_data = issue_q.src_b;
        res_d.redirect   = br_redirect;
        res_d.dnpc       = br_dnpc;
        res_d.csr_wen    = csr_wen;
        res_d.csr_wdata  = csr_wdata;
    end

    // result register
    exu_pipe_reg #(
        .payload_t(result_t)
    ) u_result (
        .clk     (clk),
        .rst     (rst),
        .up_valid(issue_valid),
        .up_ready(issue_ready),
        .up_data (res_d),
        .dn_valid(out_valid),
        .dn_ready(out_ready),
        .dn_data (res_q)
    );

    assign out_pc         = res_q.pc;
    assign out_inst       = res_q.inst;
    assign out_op         = res_q.op;
    assign out_alu        = res_q.alu_out;
    assign out_store_data = res_q.store_data;
    assign out_redirect   = res_q.redirect;
    assign out_dnpc       = res_q.dnpc;
    assign out_csr_wen    = res_q.csr_wen;
    assign out_csr_wdata  = res_q.csr_wdata;

endmodule

`default_nettype wire

// File: bench/exu_chk.sv
`timescale 1ns/10ps
`default_nettype none

module exu_chk (
    input logic              clk,
    input logic              rst,
    input logic              out_valid,
    input logic              out_ready,
    input exu_pkg::xlen_t    out_pc,
    input exu_pkg::inst_t    out_inst,
    input exu_pkg::exu_op_t  out_op,
    input exu_pkg::xlen_t    out_alu,
    input exu_pkg::xlen_t    out_store_data,
    input logic              out_redirect,
    input exu_pkg::xlen_t    out_dnpc,
    input exu_pkg::csr_wen_t out_csr_wen,
    input exu_pkg::xlen_t    out_csr_wdata
);

    // memory stage stalls, item and payload stay put
    hold_under_stall: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable({out_pc, out_inst, out_op, out_alu,
            out_store_data, out_redirect, out_dnpc, out_csr_wen, out_csr_wdata})
    ) else $error("result payload changed while the memory stage stalled");

    // at most one csr written per instruction
    one_csr_write: assert property (
        @(posedge clk) disable iff (rst) $onehot0(out_csr_wen)
    ) else $error("more than one csr write enable set");

    // bubbles carry no redirect and no csr write
    clear_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        !out_valid |-> !out_redirect && out_csr_wen == '0
    ) else $error("redirect or csr enable set while out_valid is low");

endmodule

bind exu_top exu_chk u_chk (
    .clk           (clk),
    .rst           (rst),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_pc        (out_pc),
    .out_inst      (out_inst),
    .out_op        (out_op),
    .out_alu       (out_alu),
    .out_store_data(out_store_data),
    .out_redirect  (out_redirect),
    .out_dnpc      (out_dnpc),
    .out_csr_wen   (out_csr_wen),
    .out_csr_wdata (out_csr_wdata)
);

`default_nettype wire

// File: bench/exu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exu_tb;

    import exu_pkg::*;

    localparam int N_ARITH    = 19 * 2 * 3;
    localparam int N_CONTROL  = 6 * 3 + 4;
    localparam int N_CSR      = 5 * 2;
    localparam int N_STREAM   = 200;
    localparam int N_TPUT     = 20;
    localparam int N_ITEMS    = N_ARITH + N_CONTROL + N_CSR + N_STREAM + N_TPUT;
    // ten clock periods per item plus slack for reset and drains
    localparam int WATCHDOG_NS = N_ITEMS * 10 * 40 + 1000;

    logic     clk = 1'b0;
    logic     rst;
    logic     in_valid;
    logic     in_ready;
    xlen_t    in_pc;
    inst_t    in_inst;
    exu_op_t  in_op;
    logic     in_use_imm;
    xlen_t    in_src_a;
    xlen_t    in_src_b;
    xlen_t    in_imm;
    logic     out_valid;
    logic     out_ready;
    xlen_t    out_pc;
    inst_t    out_inst;
    exu_op_t  out_op;
    xlen_t    out_alu;
    xlen_t    out_store_data;
    logic     out_redirect;
    xlen_t    out_dnpc;
    csr_wen_t out_csr_wen;
    xlen_t    out_csr_wdata;

    // scoreboard, expected results in issue order
    result_t expq[$];
    int      out_cyc[$];
    int      cyc = 0;
    int      last_acc;
    int      errors = 0;
    int      issued = 0;
    int      checked = 0;
    logic    bp_on = 1'b0;
    xlen_t   pc_ctr = 64'h0000_0000_8000_0000;

    always #20 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // random stalls from the memory side when enabled
    always @(posedge clk) out_ready <= bp_on ? 1'($urandom_range(0, 1)) : 1'b1;

    exu_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_pc         (in_pc),
        .in_inst       (in_inst),
        .in_op         (in_op),
        .in_use_imm    (in_use_imm),
        .in_src_a      (in_src_a),
        .in_src_b      (in_src_b),
        .in_imm        (in_imm),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_pc        (out_pc),
        .out_inst      (out_inst),
        .out_op        (out_op),
        .out_alu       (out_alu),
        .out_store_data(out_store_data),
        .out_redirect  (out_redirect),
        .out_dnpc      (out_dnpc),
        .out_csr_wen   (out_csr_wen),
        .out_csr_wdata (out_csr_wdata)
    );

    task automatic check_field(input string name, input xlen_t want, input xlen_t got);
        assert (want === got) else begin
            $display("FAIL %0t %s expected %h got %h", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic want, input logic got);
        assert (want === got) else begin
            $display("FAIL %0t %s expected %b got %b", $time, name, want, got);
            errors++;
        end
    endtask

    // expected stage output, built from the execute rules
    function automatic result_t expect_result(input issue_t it);
        result_t     r;
        xlen_t       a;
        xlen_t       b;
        logic [31:0] w;
        logic        lt_s;
        logic        lt_u;
        logic        taken;
        r = '0;
        r.pc         = it.pc;
        r.inst       = it.inst;
        r.op         = it.op;
        r.store_data = it.src_b;
        a = it.src_a;
        if (it.op == OP_LUI) a = '0;
        if (it.op inside {OP_AUIPC, OP_JAL, OP_JALR}) a = it.pc;
        b = (it.use_imm || it.op inside {OP_LUI, OP_AUIPC, OP_LOAD, OP_STORE}) ? it.imm : it.src_b;
        w = '0;
        case (it.op)
            OP_ADD, OP_LUI, OP_AUIPC, OP_LOAD, OP_STORE: r.alu_out = a + b;
            OP_JAL, OP_JALR: r.alu_out = it.pc + 64'd4;
            OP_SUB:  r.alu_out = a - b;
            OP_SLL:  r.alu_out = a << b[5:0];
            // sign bits decide when they differ
            OP_SLT:  r.alu_out = {63'b0, (a[63] != b[63]) ? a[63] : (a < b)};
            OP_SLTU: r.alu_out = {63'b0, a < b};
            OP_XOR:  r.alu_out = a ^ b;
            OP_SRL:  r.alu_out = a >> b[5:0];
            OP_SRA:  r.alu_out = a[63] ? ~((~a) >> b[5:0]) : (a >> b[5:0]);
            OP_OR:   r.alu_out = a | b;
            OP_AND:  r.alu_out = a & b;
            OP_ADDW: w = a[31:0] + b[31:0];
            OP_SUBW: w = a[31:0] - b[31:0];
            OP_SLLW: w = a[31:0] << b[4:0];
            OP_SRLW: w = a[31:0] >> b[4:0];
            OP_SRAW: w = a[31] ? ~((~a[31:0]) >> b[4:0]) : (a[31:0] >> b[4:0]);
            OP_CSRRW, OP_CSRRS: r.alu_out = it.src_b;
            default: r.alu_out = '0;
        endcase
        if (it.op inside {OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW}) begin
            r.alu_out = {{32{w[31]}}, w};
        end
        // branch compare on the register operands
        lt_u = it.src_a < it.src_b;
        lt_s = (it.src_a[63] != it.src_b[63]) ? it.src_a[63] : lt_u;
        case (it.op)
            OP_BEQ:  taken = it.src_a == it.src_b;
            OP_BNE:  taken = it.src_a != it.src_b;
            OP_BLT:  taken = lt_s;
            OP_BGE:  taken = !lt_s;
            OP_BLTU: taken = lt_u;
            OP_BGEU: taken = !lt_u;
            default: taken = 1'b0;
        endcase
        r.redirect = taken || it.op inside {OP_JAL, OP_JALR, OP_ECALL, OP_MRET};
        r.dnpc     = it.pc + 64'd4;
        if (taken || it.op == OP_JAL) r.dnpc = it.pc + it.imm;
        if (it.op == OP_JALR) r.dnpc = (it.src_a + it.imm) & ~64'd1;
        if (it.op inside {OP_ECALL, OP_MRET}) r.dnpc = it.src_b;
        // csr enables in order mtvec, mepc, mcause, mstatus
        if (it.op inside {OP_CSRRW, OP_CSRRS}) begin
            case (it.inst[31:20])
                12'h305: r.csr_wen = 4'b0001;
                12'h341: r.csr_wen = 4'b0010;
                12'h342: r.csr_wen = 4'b0100;
                12'h300: r.csr_wen = 4'b1000;
                default: r.csr_wen = 4'b0000;
            endcase
            r.csr_wdata = (it.op == OP_CSRRW) ? it.src_a : (it.src_a | it.src_b);
        end
        return r;
    endfunction

    function automatic issue_t rand_item(input exu_op_t op);
        issue_t it;
        it.pc      = '0;
        it.inst    = $urandom();
        it.op      = op;
        it.use_imm = 1'($urandom_range(0, 1));
        it.src_a   = {$urandom(), $urandom()};
        it.src_b   = {$urandom(), $urandom()};
        it.imm     = {$urandom(), $urandom()};
        return it;
    endfunction

    // holds valid until the stage takes the item
    task automatic send(input issue_t it);
        it.pc = pc_ctr;
        pc_ctr += 64'd4;
        in_valid   <= 1'b1;
        in_pc      <= it.pc;
        in_inst    <= it.inst;
        in_op      <= it.op;
        in_use_imm <= it.use_imm;
        in_src_a   <= it.src_a;
        in_src_b   <= it.src_b;
        in_imm     <= it.imm;
        @(posedge clk);
        while (!in_ready) @(posedge clk);
        expq.push_back(expect_result(it));
        last_acc = cyc;
        issued++;
    endtask

    task automatic drain();
        in_valid <= 1'b0;
        while (expq.size() != 0) @(posedge clk);
        @(posedge clk);
    endtask

    task automatic report(input string name, input int err0);
        $display("test %s finished with %0d errors", name, errors - err0);
    endtask

    // compare every output transfer against the oldest expected item
    always @(posedge clk) begin : monitor
        result_t want;
        if (!rst && out_valid && out_ready) begin
            out_cyc.push_back(cyc);
            assert (expq.size() != 0) else begin
                $display("error at %0t: output transfer with no instruction outstanding", $time);
                errors++;
            end
            if (expq.size() != 0) begin
                want = expq.pop_front();
                check_field("out_pc", want.pc, out_pc);
                check_field("out_inst", 64'(want.inst), 64'(out_inst));
                check_field("out_op", 64'(want.op), 64'(out_op));
                check_field("out_alu", want.alu_out, out_alu);
                check_field("out_store_data", want.store_data, out_store_data);
                check_bit("out_redirect", want.redirect, out_redirect);
                check_field("out_dnpc", want.dnpc, out_dnpc);
                check_field("out_csr_wen", 64'(want.csr_wen), 64'(out_csr_wen));
                check_field("out_csr_wdata", want.csr_wdata, out_csr_wdata);
                checked++;
            end
        end
    end

    task automatic run_reset_test();
        int err0;
        err0 = errors;
        repeat (15) begin
            @(posedge clk);
            @(negedge clk);
            check_bit("out_valid", 1'b0, out_valid);
            check_bit("in_ready", 1'b1, in_ready);
        end
        // sixteenth edge in reset
        @(posedge clk);
        rst <= 1'b0;
        repeat (6) begin
            @(negedge clk);
            check_bit("out_valid", 1'b0, out_valid);
            check_bit("in_ready", 1'b1, in_ready);
        end
        @(posedge clk);
        report("reset", err0);
    endtask

    task automatic run_arith_test();
        int      err0;
        exu_op_t op;
        issue_t  it;
        err0 = errors;
        for (int k = 0; k < 32; k++) begin
            op = exu_op_t'(k);
            if (op inside {OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA,
                           OP_OR, OP_AND, OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
                           OP_LUI, OP_AUIPC, OP_LOAD, OP_STORE}) begin
                // register form then immediate form
                for (int f = 0; f < 2; f++) begin
                    repeat (3) begin
                        it = rand_item(op);
                        it.use_imm = (f == 1);
                        send(it);
                    end
                end
            end
        end
        drain();
        report("arith", err0);
    endtask

    task automatic run_control_test();
        int      err0;
        exu_op_t op;
        issue_t  it;
        xlen_t   neg;
        xlen_t   pos;
        err0 = errors;
        neg = 64'hffff_ffff_ffff_fffb;
        pos = 64'd3;
        // equal, negative against positive, and reversed
        for (int k = 0; k < 32; k++) begin
            op = exu_op_t'(k);
            if (op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU}) begin
                it = rand_item(op);
                it.src_a = neg;
                it.src_b = neg;
                send(it);
                it.src_b = pos;
                send(it);
                it.src_a = pos;
                it.src_b = neg;
                send(it);
            end
        end
        send(rand_item(OP_JAL));
        // odd jalr sum, target bit 0 must clear
        it = rand_item(OP_JALR);
        it.imm[0] = ~it.src_a[0];
        send(it);
        send(rand_item(OP_ECALL));
        send(rand_item(OP_MRET));
        drain();
        report("control", err0);
    endtask

    task automatic run_csr_test();
        int          err0;
        logic [11:0] addrs[5];
        issue_t      it;
        err0 = errors;
        addrs = '{CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MSTATUS, 12'h7c0};
        foreach (addrs[i]) begin
            it = rand_item(OP_CSRRW);
            it.inst[31:20] = addrs[i];
            send(it);
            it = rand_item(OP_CSRRS);
            it.inst[31:20] = addrs[i];
            send(it);
        end
        drain();
        report("csr", err0);
    endtask

    task automatic run_stream_test();
        int err0;
        err0 = errors;
        bp_on <= 1'b1;
        repeat (N_STREAM) send(rand_item(exu_op_t'($urandom_range(0, 31))));
        bp_on <= 1'b0;
        drain();
        report("stream", err0);
    endtask

    task automatic run_throughput_test();
        int err0;
        int first_acc;
        int prev_acc;
        err0 = errors;
        first_acc = 0;
        prev_acc = 0;
        out_cyc.delete();
        for (int i = 0; i < N_TPUT; i++) begin
            send(rand_item(exu_op_t'($urandom_range(0, 31))));
            if (i == 0) begin
                first_acc = last_acc;
            end else begin
                assert (last_acc == prev_acc + 1) else begin
                    $display("error at %0t: input %0d not taken on the next cycle", $time, i);
                    errors++;
                end
            end
            prev_acc = last_acc;
        end
        drain();
        assert (out_cyc.size() == N_TPUT) else begin
            $display("error at %0t: %0d outputs seen for %0d inputs", $time, out_cyc.size(), N_TPUT);
            errors++;
        end
        // first transfer two edges after the accepting edge, then one per cycle
        foreach (out_cyc[i]) begin
            assert (out_cyc[i] == first_acc + 2 + i) else begin
                $display("FAIL %0t out_valid expected transfer at cycle %0d got cycle %0d",
                         $time, first_acc + 2 + i, out_cyc[i]);
                errors++;
            end
        end
        report("throughput", err0);
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: stage stopped making progress after %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    initial begin : main
        void'($urandom(20));
        rst        = 1'b1;
        out_ready  = 1'b1;
        in_valid   = 1'b0;
        in_pc      = '0;
        in_inst    = '0;
        in_op      = OP_NOP;
        in_use_imm = 1'b0;
        in_src_a   = '0;
        in_src_b   = '0;
        in_imm     = '0;
        run_reset_test();
        run_arith_test();
        run_control_test();
        run_csr_test();
        run_stream_test();
        run_throughput_test();
        assert (expq.size() == 0) else begin
            $display("error: %0d instructions never left the stage", expq.size());
            errors++;
        end
        $display("summary: %0d issued, %0d checked, %0d errors", issued, checked, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hdl/exu_pkg.sv
hdl/exu_pipe_reg.sv
hdl/exu_alu.sv
hdl/exu_branch.sv
hdl/exu_csr_wr.sv
hdl/exu_top.sv
bench/exu_chk.sv
bench/exu_tb.sv

// File: Makefile
TOP := exu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f src.f
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	! grep -q "Verification failed" sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
